// ==== common/forthCorePkg.sv ====
`default_nettype none

package forthCorePkg;

	// Data word and byte address
	typedef logic [15:0] word;

	// Register number, 0 to 15
	typedef logic [3:0] regIndex;

	// Accumulator RA
	localparam regIndex regA = 4'd15;

	// Instruction bits 15:14
	typedef enum logic [1:0] {
		groupAlu       = 2'b00,
		groupLoadStore = 2'b01,
		// Reserved, executed as no-operation
		groupRsvd2     = 2'b10,
		groupRsvd3     = 2'b11
	} groupCode;

	// ALU format bits 13:11, codes 6 and 7 unused
	typedef enum logic [2:0] {
		mov   = 3'd0,
		add   = 3'd1,
		sub   = 3'd2,
		andOp = 3'd3,
		orOp  = 3'd4,
		xorOp = 3'd5
	} aluOp;

	// ALU format bits 10:9
	typedef enum logic [1:0] {
		regReg = 2'b00,
		regU4  = 2'b01,
		raU8   = 2'b10,
		raS8   = 2'b11
	} aluMode;

	// Load/store format bits 12:11
	typedef enum logic [1:0] {
		ld  = 2'b00,
		st  = 2'b01,
		ldb = 2'b10,
		stb = 2'b11
	} lsOp;

	// Load/store format bits 10:9, code 3 behaves as plain
	typedef enum logic [1:0] {
		plain   = 2'b00,
		postInc = 2'b01,
		preDec  = 2'b10
	} lsMode;

	// Bits 7:0 are dst:src, dst:u4 or a full 8-bit immediate
	typedef struct packed {
		groupCode group;
		aluOp op;
		aluMode mode;
		logic spare;
		regIndex dst;
		regIndex src;
	} aluFormat;

	typedef struct packed {
		groupCode group;
		logic spare13;
		lsOp op;
		lsMode mode;
		logic spare8;
		regIndex dataReg;
		regIndex baseReg;
	} lsFormat;

	// Same word, two views
	typedef union packed {
		aluFormat alu;
		lsFormat ls;
	} instrWord;

	// Base register update for postInc and preDec
	typedef enum logic [1:0] {
		ptrNone = 2'b00,
		ptrInc  = 2'b01,
		ptrDec  = 2'b10
	} ptrUpd;

	// Decoded control, combinational from the IR
	typedef struct packed {
		logic isAlu;
		logic isLoad;
		logic isStore;
		logic isByte;
		aluOp op;
		// Data register for load/store, ALU destination otherwise
		regIndex dst;
		// Base register for load/store
		regIndex src;
		logic useImm;
		word imm;
		ptrUpd ptr;
	} ctrlBus;

	// External bus, strobes active low
	typedef struct packed {
		word addr;
		word dout;
		logic rdN;
		logic wrN0;
		logic wrN1;
	} memBus;

endpackage

`default_nettype wire

// ==== core/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
	input  forthCorePkg::instrWord instr,
	output forthCorePkg::ctrlBus ctrl
);

	import forthCorePkg::*;

	always_comb begin
		// Default is a no-operation, nothing written
		ctrl = '0;
		ctrl.op = mov;
		ctrl.ptr = ptrNone;

		case (instr.alu.group)
			groupAlu: begin
				// Unused op codes 6 and 7 write nothing
				ctrl.isAlu = instr.alu.op inside {mov, add, sub, andOp, orOp, xorOp};
				ctrl.op = instr.alu.op;
				case (instr.alu.mode)
					regReg: begin
						ctrl.dst = instr.alu.dst;
						ctrl.src = instr.alu.src;
						ctrl.useImm = 1'b0;
					end
					regU4: begin
						// Source field is the immediate
						ctrl.dst = instr.alu.dst;
						ctrl.src = instr.alu.src;
						ctrl.useImm = 1'b1;
						ctrl.imm = {12'h000, instr.alu.src};
					end
					raU8: begin
						ctrl.dst = regA;
						ctrl.src = regA;
						ctrl.useImm = 1'b1;
						ctrl.imm = {8'h00, instr.alu.dst, instr.alu.src};
					end
					default: begin
						// raS8, sign taken from bit 7
						ctrl.dst = regA;
						ctrl.src = regA;
						ctrl.useImm = 1'b1;
						ctrl.imm = {{8{instr.alu.dst[3]}}, instr.alu.dst, instr.alu.src};
					end
				endcase
			end
			groupLoadStore: begin
				ctrl.isLoad = (instr.ls.op == ld) || (instr.ls.op == ldb);
				ctrl.isStore = (instr.ls.op == st) || (instr.ls.op == stb);
				ctrl.isByte = (instr.ls.op == ldb) || (instr.ls.op == stb);
				ctrl.dst = instr.ls.dataReg;
				ctrl.src = instr.ls.baseReg;
				case (instr.ls.mode)
					postInc: ctrl.ptr = ptrInc;
					preDec: ctrl.ptr = ptrDec;
					default: ctrl.ptr = ptrNone;
				endcase
			end
			default: begin
				// Reserved groups keep the defaults
				ctrl.isAlu = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== core/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic CLK,
	input  logic reset,
	input  forthCorePkg::regIndex rdAddr0,
	input  forthCorePkg::regIndex rdAddr1,
	output forthCorePkg::word rdData0,
	output forthCorePkg::word rdData1,
	input  logic wrEn,
	input  logic ptrEn,
	input  forthCorePkg::regIndex wrAddr,
	input  forthCorePkg::regIndex ptrAddr,
	input  forthCorePkg::word wrData,
	input  forthCorePkg::word ptrData
);

	import forthCorePkg::*;

	// R0 to R14, R15 is RA
	word regs [16];

	// Result port wins over the pointer port on the same register,
	// so a load into its own base keeps the loaded value
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ptrEn) begin
				regs[ptrAddr] <= ptrData;
			end
			if (wrEn) begin
				regs[wrAddr] <= wrData;
			end
		end
	end

	// Asynchronous reads
	assign rdData0 = regs[rdAddr0];
	assign rdData1 = regs[rdAddr1];

	// Priority of the result write on a shared target
	property resultWinsP;
		@(posedge CLK) disable iff (reset)
		(wrEn && ptrEn && (wrAddr == ptrAddr)) |=> (regs[$past(wrAddr)] == $past(wrData));
	endproperty
	resultWins: assert property (resultWinsP)
		else $error("Pointer write overrode result write");

endmodule

`default_nettype wire

// ==== core/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  forthCorePkg::ctrlBus ctrl,
	input  forthCorePkg::word opA,
	input  forthCorePkg::word opB,
	output forthCorePkg::word result
);

	import forthCorePkg::*;

	// Second operand after immediate selection
	word operand;

	always_comb begin
		if (ctrl.useImm) begin
			operand = ctrl.imm;
		end else begin
			operand = opB;
		end
	end

	// All arithmetic wraps at 16 bits
	always_comb begin
		case (ctrl.op)
			mov: begin
				// Pass through
				result = operand;
			end
			add: begin
				result = opA + operand;
			end
			sub: begin
				// Destination minus operand
				result = opA - operand;
			end
			andOp: begin
				result = opA & operand;
			end
			orOp: begin
				result = opA | operand;
			end
			xorOp: begin
				result = opA ^ operand;
			end
			default: begin
				// Unused codes, destination unchanged
				result = opA;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== core/coreControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreControl (
	input  logic CLK,
	input  logic reset,
	input  forthCorePkg::word din,
	output forthCorePkg::instrWord instr,
	input  forthCorePkg::ctrlBus ctrl,
	input  forthCorePkg::word rdData0,
	input  forthCorePkg::word rdData1,
	input  forthCorePkg::word aluResult,
	output forthCorePkg::regIndex rdAddr0,
	output forthCorePkg::regIndex rdAddr1,
	output logic wrEn,
	output logic ptrEn,
	output forthCorePkg::regIndex wrAddr,
	output forthCorePkg::regIndex ptrAddr,
	output forthCorePkg::word wrData,
	output forthCorePkg::word ptrData,
	output forthCorePkg::memBus bus,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	import forthCorePkg::*;

	// One-hot, bit 0 fetch up to bit 3 commit
	logic [3:0] phase;
	word pc;
	word step;
	word baseAddr;
	word effAddr;
	word loadValue;
	logic memAccess;

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= 4'b0000;
		end else if (phase == 4'b0000) begin
			// First edge after reset starts at fetch
			phase <= 4'b0001;
		end else begin
			phase <= {phase[2:0], phase[3]};
		end
	end

	assign fetch = phase[0];
	assign decode = phase[1];
	assign execute = phase[2];
	assign commit = phase[3];

	// PC steps at the end of commit
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (commit) begin
			pc <= pc + 16'd2;
		end
	end

	// Memory shows the instruction during decode
	always_ff @(posedge CLK) begin
		if (reset) begin
			instr <= '0;
		end else if (decode) begin
			instr <= instrWord'(din);
		end
	end

	// Port 0 data or destination, port 1 base or source
	assign rdAddr0 = ctrl.dst;
	assign rdAddr1 = ctrl.src;

	// Byte accesses step by 1, words by 2
	assign step = ctrl.isByte ? 16'd1 : 16'd2;
	assign baseAddr = rdData1;
	assign effAddr = (ctrl.ptr == ptrDec) ? (baseAddr - step) : baseAddr;
	assign memAccess = ctrl.isLoad || ctrl.isStore;

	// Selected byte zero-extended
	always_comb begin
		if (!ctrl.isByte) begin
			loadValue = din;
		end else if (effAddr[0]) begin
			loadValue = {8'h00, din[15:8]};
		end else begin
			loadValue = {8'h00, din[7:0]};
		end
	end

	// Both writes land at the end of commit
	assign wrEn = commit && (ctrl.isAlu || ctrl.isLoad);
	assign wrAddr = ctrl.dst;
	assign wrData = ctrl.isLoad ? loadValue : aluResult;
	assign ptrEn = commit && memAccess && (ctrl.ptr != ptrNone);
	assign ptrAddr = ctrl.src;
	assign ptrData = (ctrl.ptr == ptrInc) ? (baseAddr + step) : (baseAddr - step);

	always_comb begin
		// PC in fetch and decode, data address after
		if (fetch || decode || !memAccess) begin
			bus.addr = pc;
		end else if (ctrl.isByte) begin
			bus.addr = effAddr;
		end else begin
			bus.addr = {effAddr[15:1], 1'b0};
		end

		// Byte goes on its own lane, zero on the other
		if (!ctrl.isByte) begin
			bus.dout = rdData0;
		end else if (effAddr[0]) begin
			bus.dout = {rdData0[7:0], 8'h00};
		end else begin
			bus.dout = {8'h00, rdData0[7:0]};
		end

		bus.rdN = !(fetch || decode || ((execute || commit) && ctrl.isLoad));
		// Writes only in commit
		bus.wrN0 = !(commit && ctrl.isStore && (!ctrl.isByte || !effAddr[0]));
		bus.wrN1 = !(commit && ctrl.isStore && (!ctrl.isByte || effAddr[0]));
	end

	// No read and write on the bus at once
	noBusClash: assert property (@(posedge CLK) disable iff (reset)
		!(!bus.rdN && (!bus.wrN0 || !bus.wrN1)))
		else $error("Read and write strobes low together");

	// Write strobes confined to commit
	writeInCommit: assert property (@(posedge CLK) disable iff (reset)
		(!bus.wrN0 || !bus.wrN1) |-> commit)
		else $error("Write strobe outside commit");

	// One phase at a time once running
	onePhase: assert property (@(posedge CLK) disable iff (reset)
		!$past(reset) |-> $onehot(phase))
		else $error("Phase strobes not one-hot");

endmodule

`default_nettype wire

// ==== design/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core (
	input  logic CLK,
	input  logic reset,
	input  forthCorePkg::word din,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output forthCorePkg::word addrBuf,
	output forthCorePkg::word doutBuf,
	output logic rdnBuf,
	output logic wrn0Buf,
	output logic wrn1Buf
);

	import forthCorePkg::*;

	instrWord instr;
	ctrlBus ctrl;
	word rdData0;
	word rdData1;
	word aluResult;
	regIndex rdAddr0;
	regIndex rdAddr1;
	logic wrEn;
	logic ptrEn;
	regIndex wrAddr;
	regIndex ptrAddr;
	word wrData;
	word ptrData;
	memBus bus;

	// Sequencer, PC, IR and bus
	coreControl u_coreControl (
		.CLK(CLK),
		.reset(reset),
		.din(din),
		.instr(instr),
		.ctrl(ctrl),
		.rdData0(rdData0),
		.rdData1(rdData1),
		.aluResult(aluResult),
		.rdAddr0(rdAddr0),
		.rdAddr1(rdAddr1),
		.wrEn(wrEn),
		.ptrEn(ptrEn),
		.wrAddr(wrAddr),
		.ptrAddr(ptrAddr),
		.wrData(wrData),
		.ptrData(ptrData),
		.bus(bus),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	instructionDecoder u_instructionDecoder (
		.instr(instr),
		.ctrl(ctrl)
	);

	registerFile u_registerFile (
		.CLK(CLK),
		.reset(reset),
		.rdAddr0(rdAddr0),
		.rdAddr1(rdAddr1),
		.rdData0(rdData0),
		.rdData1(rdData1),
		.wrEn(wrEn),
		.ptrEn(ptrEn),
		.wrAddr(wrAddr),
		.ptrAddr(ptrAddr),
		.wrData(wrData),
		.ptrData(ptrData)
	);

	// Destination on port 0, source on port 1
	aluUnit u_aluUnit (
		.ctrl(ctrl),
		.opA(rdData0),
		.opB(rdData1),
		.result(aluResult)
	);

	// Bus struct out to pins
	assign addrBuf = bus.addr;
	assign doutBuf = bus.dout;
	assign rdnBuf = bus.rdN;
	assign wrn0Buf = bus.wrN0;
	assign wrn1Buf = bus.wrN1;

endmodule

`default_nettype wire

// ==== bench/coreModel.svh ====
`ifndef coreModelSvh
`define coreModelSvh

// Instruction-set model state
word modelRegs [16];
word modelMem [4096];
word modelPc;

// Image loaded into the bus memory during reset
word progMem [4096];

logic [31:0] lcgState;

// Upper bits of the LCG state are the useful ones
function automatic logic [31:0] nextRandom();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

// Random data everywhere with the program in the low words
task automatic generateProgram();
	instrWord w;
	logic [31:0] r;
	logic [31:0] s;
	for (int i = 0; i < 4096; i++) begin
		r = nextRandom();
		progMem[i] = r[31:16];
	end
	for (int i = 0; i < numInstr; i++) begin
		r = nextRandom();
		s = nextRandom();
		// Random fields, then the ones that matter are forced
		w = instrWord'(r[31:16]);
		if (i < 6) begin
			// Prologue points R12 to R14 into the top of memory
			w.alu.group = groupAlu;
			w.alu.op = mov;
			if (i % 2 == 0) begin
				w.alu.mode = raS8;
				w.alu.dst[3] = 1'b1;
			end else begin
				w.alu.mode = regReg;
				w.alu.dst = 4'(12 + i / 2);
				w.alu.src = regA;
			end
		end else if (i >= numInstr - 16) begin
			// Epilogue dumps every register through R13
			w.ls.group = groupLoadStore;
			w.ls.op = st;
			w.ls.mode = postInc;
			w.ls.dataReg = 4'(i - (numInstr - 16));
			w.ls.baseReg = 4'd13;
		end else if (s[31:28] < 4'd8) begin
			w.alu.group = groupAlu;
			w.alu.op = aluOp'(3'(s[27:24] % 4'd6));
			w.alu.mode = aluMode'(s[21:20]);
			// Keep pointers mostly intact in the register modes
			if ((w.alu.mode inside {regReg, regU4}) && (w.alu.dst inside {12, 13, 14})) begin
				w.alu.dst = regA;
			end
		end else if (s[31:28] < 4'd14) begin
			w.ls.group = groupLoadStore;
			w.ls.op = lsOp'(s[21:20]);
			w.ls.baseReg = 4'd12 + 4'(s[27:24] % 4'd3);
			// Data register often forced onto the base to hit the shared write
			if (s[19:18] == 2'b00) begin
				w.ls.dataReg = w.ls.baseReg;
			end
		end else begin
			// Reserved group
			w.alu.group = groupCode'({1'b1, s[20]});
		end
		progMem[i] = word'(w);
	end
	for (int i = 0; i < 4096; i++) begin
		modelMem[i] = progMem[i];
	end
endtask

// Runs one instruction at modelPc and returns the expected execute and commit bus
task automatic modelExecute(output memBus execBus, output memBus commitBus,
		output logic isStore);
	instrWord w;
	word raw;
	regIndex d;
	word opB;
	word base;
	word step;
	word eff;
	word addr;
	word data;
	logic isByte;
	logic isLoad;
	raw = modelMem[modelPc[12:1]];
	w = instrWord'(raw);
	// Non-memory instructions keep the PC on the bus
	execBus.addr = modelPc;
	execBus.dout = '0;
	execBus.rdN = 1'b1;
	execBus.wrN0 = 1'b1;
	execBus.wrN1 = 1'b1;
	commitBus = execBus;
	isStore = 1'b0;
	if (w.alu.group == groupAlu) begin
		d = w.alu.dst;
		opB = modelRegs[w.alu.src];
		case (w.alu.mode)
			regU4: begin
				opB = {12'h000, w.alu.src};
			end
			raU8: begin
				d = regA;
				opB = {8'h00, raw[7:0]};
			end
			raS8: begin
				d = regA;
				opB = {{8{raw[7]}}, raw[7:0]};
			end
			default: begin
				d = w.alu.dst;
			end
		endcase
		case (w.alu.op)
			mov: modelRegs[d] = opB;
			add: modelRegs[d] = modelRegs[d] + opB;
			sub: modelRegs[d] = modelRegs[d] - opB;
			andOp: modelRegs[d] = modelRegs[d] & opB;
			orOp: modelRegs[d] = modelRegs[d] | opB;
			xorOp: modelRegs[d] = modelRegs[d] ^ opB;
			// Op codes 6 and 7 leave everything alone
			default: d = w.alu.dst;
		endcase
	end else if (w.ls.group == groupLoadStore) begin
		isByte = (w.ls.op == ldb) || (w.ls.op == stb);
		isLoad = (w.ls.op == ld) || (w.ls.op == ldb);
		isStore = !isLoad;
		step = isByte ? 16'd1 : 16'd2;
		base = modelRegs[w.ls.baseReg];
		eff = (w.ls.mode == preDec) ? (base - step) : base;
		addr = isByte ? eff : {eff[15:1], 1'b0};
		execBus.addr = addr;
		execBus.rdN = !isLoad;
		data = modelRegs[w.ls.dataReg];
		if (isStore && !isByte) begin
			execBus.dout = data;
			modelMem[addr[12:1]] = data;
		end else if (isStore && eff[0]) begin
			// Odd byte on the high lane
			execBus.dout = {data[7:0], 8'h00};
			modelMem[addr[12:1]][15:8] = data[7:0];
		end else if (isStore) begin
			execBus.dout = {8'h00, data[7:0]};
			modelMem[addr[12:1]][7:0] = data[7:0];
		end
		commitBus = execBus;
		if (isStore && !isByte) begin
			// Word store strobes both lanes
			commitBus.wrN0 = 1'b0;
			commitBus.wrN1 = 1'b0;
		end else if (isStore && eff[0]) begin
			commitBus.wrN1 = 1'b0;
		end else if (isStore) begin
			commitBus.wrN0 = 1'b0;
		end
		if (w.ls.mode == postInc) begin
			modelRegs[w.ls.baseReg] = base + step;
		end else if (w.ls.mode == preDec) begin
			modelRegs[w.ls.baseReg] = base - step;
		end
		// Loaded value written last, so it beats the pointer
		if (isLoad) begin
			data = modelMem[addr[12:1]];
			if (isByte) begin
				data = eff[0] ? {8'h00, data[15:8]} : {8'h00, data[7:0]};
			end
			modelRegs[w.ls.dataReg] = data;
		end
	end
	modelPc = modelPc + 16'd2;
endtask

`endif

// ==== bench/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	import forthCorePkg::*;

	localparam int numInstr = 200;
	localparam int phaseTimeout = 20;

	logic CLK;
	logic reset = 1'b1;
	word din = '0;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	word addrBuf;
	word doutBuf;
	logic rdnBuf;
	logic wrn0Buf;
	logic wrn1Buf;

	// Memory on the DUT bus, word index from address bits 12:1
	word mem [4096];

	// Outputs regrouped for the compare tasks
	memBus gotBus;
	logic [3:0] phases;

	`include "coreModel.svh"

	core u_core (
		.CLK(CLK),
		.reset(reset),
		.din(din),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.addrBuf(addrBuf),
		.doutBuf(doutBuf),
		.rdnBuf(rdnBuf),
		.wrn0Buf(wrn0Buf),
		.wrn1Buf(wrn1Buf)
	);

	assign gotBus = {addrBuf, doutBuf, rdnBuf, wrn0Buf, wrn1Buf};
	assign phases = {commit, execute, decode, fetch};

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Image reloaded while in reset, then read and byte-lane writes
	always @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 4096; i++) begin
				mem[i] <= progMem[i];
			end
		end else begin
			if (!rdnBuf) begin
				din <= mem[addrBuf[12:1]];
			end
			if (!wrn0Buf) begin
				mem[addrBuf[12:1]][7:0] <= doutBuf[7:0];
			end
			if (!wrn1Buf) begin
				mem[addrBuf[12:1]][15:8] <= doutBuf[15:8];
			end
		end
	end

	task automatic stopOnFailure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input word got, input word expected);
		if (got !== expected) begin
			$display("MISMATCH %s got %h expected %h", name, got, expected);
			stopOnFailure();
		end
	endtask

	// Strobes only, rdN wrN0 wrN1
	task automatic checkBus(input memBus got, input memBus expected);
		if ({got.rdN, got.wrN0, got.wrN1} !== {expected.rdN, expected.wrN0, expected.wrN1}) begin
			$display("MISMATCH bus strobes rdN/wrN0/wrN1 got %h expected %h",
				{got.rdN, got.wrN0, got.wrN1}, {expected.rdN, expected.wrN0, expected.wrN1});
			stopOnFailure();
		end
	endtask

	task automatic checkPhases(input logic [3:0] got, input logic [3:0] expected);
		if (got !== expected) begin
			$display("MISMATCH phase strobes got %h expected %h", got, expected);
			stopOnFailure();
		end
	endtask

	// Each phase must follow the previous one after exactly one cycle
	task automatic waitForPhase(input int index, input string name);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < phaseTimeout) begin
			@(negedge CLK);
			cycles++;
			seen = phases[index];
		end
		if (!seen) begin
			$display("Timeout: no %s strobe within %0d cycles", name, phaseTimeout);
			stopOnFailure();
		end
		if (cycles != 1) begin
			$display("The %s strobe came after %0d cycles instead of 1", name, cycles);
			stopOnFailure();
		end
	endtask

	task automatic checkPhaseCycle(input int index, input string name, input memBus expected,
			input logic isStore);
		waitForPhase(index, name);
		checkPhases(phases, 4'b0001 << index);
		checkWord("addrBuf", addrBuf, expected.addr);
		checkBus(gotBus, expected);
		if (isStore) begin
			checkWord("doutBuf", doutBuf, expected.dout);
		end
	endtask

	// Reset state, no strobes and PC 0 on the bus
	task automatic checkIdle();
		memBus idleBus;
		idleBus = '0;
		idleBus.rdN = 1'b1;
		idleBus.wrN0 = 1'b1;
		idleBus.wrN1 = 1'b1;
		checkPhases(phases, 4'b0000);
		checkWord("addrBuf", addrBuf, 16'h0000);
		checkBus(gotBus, idleBus);
	endtask

	task automatic runInstruction();
		memBus fetchBus;
		memBus execBus;
		memBus commitBus;
		logic isStore;
		fetchBus = '0;
		fetchBus.addr = modelPc;
		fetchBus.rdN = 1'b0;
		fetchBus.wrN0 = 1'b1;
		fetchBus.wrN1 = 1'b1;
		checkPhaseCycle(0, "fetch", fetchBus, 1'b0);
		checkPhaseCycle(1, "decode", fetchBus, 1'b0);
		// Model runs ahead, only the expectations are kept
		modelExecute(execBus, commitBus, isStore);
		checkPhaseCycle(2, "execute", execBus, isStore);
		checkPhaseCycle(3, "commit", commitBus, isStore);
	endtask

	initial begin
		lcgState = 32'h2676_5c97;
		modelPc = '0;
		for (int i = 0; i < 16; i++) begin
			modelRegs[i] = '0;
		end
		generateProgram();

		// Three edges with reset high
		repeat (2) begin
			@(posedge CLK);
			@(negedge CLK);
			checkIdle();
		end
		@(posedge CLK);
		reset <= 1'b0;
		// Still idle in the first cycle after release
		@(negedge CLK);
		checkIdle();

		for (int n = 0; n < numInstr; n++) begin
			runInstruction();
		end

		// Last store lands on the next edge
		@(negedge CLK);
		for (int i = 0; i < 4096; i++) begin
			checkWord($sformatf("mem[%03h]", i), mem[i], modelMem[i]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+bench
common/forthCorePkg.sv
core/instructionDecoder.sv
core/registerFile.sv
core/aluUnit.sv
core/coreControl.sv
design/core.sv
bench/coreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module coreTb -o coreTbSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit 1
fi

output=$(./obj_dir/coreTbSim 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Run returned status $status"
	exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -q "^Simulation passed$"; then
	exit 0
else
	echo "Pass line not found in the output"
	exit 1
fi
